//--- compile.f
logic/key_map_pkg.sv
logic/paddle_pkg.sv
logic/key_decoder.sv
logic/motion_decoder.sv
logic/paddle_position.sv
logic/cabinet_outputs.sv
logic/arkanoid_controls.sv
sim/arkanoid_controls_props.sv
sim/tb_arkanoid_controls.sv

//--- sim/tb_arkanoid_controls.sv
`timescale 1ns/100ps

module tb_arkanoid_controls;

	localparam int STEP_DIV   = 6;
	localparam int POLL_DIV   = 20;
	localparam int CLK_PERIOD = 4;
	localparam int STEP_CLKS  = 2 * STEP_DIV; // Clocks per emulated step
	localparam int MAX_STEPS  = 5 + 7 + 3 * 40 + 4 + 9 + 4 + 40; // Worst case owed steps
	localparam int WATCHDOG_CLKS = MAX_STEPS * STEP_CLKS + 40 * STEP_CLKS + 2000;

	logic CLK_12M;
	logic rst_n;
	logic [10:0] ps2_key;
	logic [24:0] ps2_mouse;
	logic enc_a;
	logic enc_b;
	logic fire_in_n;
	paddle_pkg::quad_t spinner;
	logic shot_n, coin1_n, coin2_n, start1_n, start2_n, service_n;
	key_map_pkg::board_btn_t board_n;

	int errors, tests_run, tests_failed, test_start_errors;
	int pos_steps, neg_steps, bad_steps; // Spinner monitor counts
	logic count_en;
	paddle_pkg::quad_t last_q, emu_expected, raw_expected;
	integer seed = 73613;

	assign board_n = {shot_n, coin1_n, coin2_n, start1_n, start2_n, service_n};

	arkanoid_controls #(.step_div(STEP_DIV), .poll_div(POLL_DIV)) i_arkanoid_controls (
		.CLK_12M(CLK_12M), .rst_n(rst_n), .ps2_key(ps2_key), .ps2_mouse(ps2_mouse),
		.enc_a(enc_a), .enc_b(enc_b), .fire_in_n(fire_in_n), .spinner(spinner),
		.shot_n(shot_n), .coin1_n(coin1_n), .coin2_n(coin2_n),
		.start1_n(start1_n), .start2_n(start2_n), .service_n(service_n)
	);

	initial begin
		CLK_12M = 1'b0;
		forever #(CLK_PERIOD / 2) CLK_12M = ~CLK_12M;
	end

	// Encoder sequences, negative 00 01 11 10 and positive 00 10 11 01
	function automatic paddle_pkg::quad_t next_phase(input paddle_pkg::quad_t q, input logic neg);
		paddle_pkg::quad_t r;
		if (neg) begin
			case (q)
				2'b00:   r = 2'b01;
				2'b01:   r = 2'b11;
				2'b11:   r = 2'b10;
				default: r = 2'b00;
			endcase
		end else begin
			case (q)
				2'b00:   r = 2'b10;
				2'b10:   r = 2'b11;
				2'b11:   r = 2'b01;
				default: r = 2'b00;
			endcase
		end
		return r;
	endfunction

	// Spinner monitor, mid cycle where outputs are stable
	always @(negedge CLK_12M) begin
		if (count_en && spinner != last_q) begin
			if (spinner == next_phase(last_q, 1'b0)) pos_steps++;
			else if (spinner == next_phase(last_q, 1'b1)) neg_steps++;
			else bad_steps++; // Not a single Gray step
		end
		last_q = spinner;
	end

	task automatic check_buttons(input string name, input key_map_pkg::board_btn_t exp);
		if (board_n !== exp) begin
			$display("error %s: expected %b, actual %b", name, exp, board_n);
			errors++;
		end
	endtask

	task automatic check_quad(input string name, input paddle_pkg::quad_t exp);
		if (spinner !== exp) begin
			$display("error %s: expected %b, actual %b", name, exp, spinner);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (exp != act) begin
			$display("error %s: expected %0d, actual %0d", name, exp, act);
			errors++;
		end
	endtask

	// ==================================================================
	// Stimulus
	// ==================================================================
	task automatic press_key(input key_map_pkg::scan_code_t code, input logic pressed);
		@(posedge CLK_12M);
		ps2_key <= {~ps2_key[10], pressed, 1'b0, code}; // Toggle marks the report
	endtask

	task automatic send_mouse(input paddle_pkg::mouse_delta_t dx, input logic [1:0] buttons);
		@(posedge CLK_12M);
		ps2_mouse <= {~ps2_mouse[24], 8'h00, dx, 6'h00, buttons};
	endtask

	task automatic turn_encoder(input logic b);
		@(posedge CLK_12M);
		raw_expected = next_phase(raw_expected, (~enc_a) != b); // Negative when A differs from B
		enc_a <= ~enc_a;
		enc_b <= b;
	endtask

	task automatic wait_two_edges();
		repeat (2) @(posedge CLK_12M);
		@(negedge CLK_12M);
	endtask

	task automatic clear_steps();
		@(posedge CLK_12M);
		pos_steps = 0;
		neg_steps = 0;
		bad_steps = 0;
	endtask

	// Wait for n steps, then a quiet spell that would expose extra ones
	task automatic drain_steps(input string name, input int n, input logic neg);
		int waited;
		waited = 0;
		while (pos_steps + neg_steps + bad_steps < n && waited < (n + 2) * STEP_CLKS) begin
			@(posedge CLK_12M);
			waited++;
		end
		if (pos_steps + neg_steps + bad_steps < n) begin
			$display("%s: spinner stopped after %0d of %0d steps", name,
				pos_steps + neg_steps + bad_steps, n);
			errors++;
		end
		repeat (3 * STEP_CLKS) @(posedge CLK_12M);
		check_count({name, " forward"}, neg ? 0 : n, pos_steps);
		check_count({name, " backward"}, neg ? n : 0, neg_steps);
		check_count({name, " jumps"}, 0, bad_steps);
		repeat (n) emu_expected = next_phase(emu_expected, neg);
		@(negedge CLK_12M);
		check_quad({name, " phase"}, emu_expected);
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == test_start_errors) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - test_start_errors);
		end
		test_start_errors = errors;
	endtask

	// ==================================================================
	// Tests
	// ==================================================================
	task automatic test_reset_values();
		@(negedge CLK_12M);
		check_buttons("reset buttons", '1);
		check_quad("reset spinner", paddle_pkg::QUAD_IDLE);
		finish_test("reset_values");
	endtask

	task automatic test_buttons();
		key_map_pkg::scan_code_t codes[6];
		key_map_pkg::board_btn_t exp;
		codes = '{key_map_pkg::SC_FIRE, key_map_pkg::SC_COIN1, key_map_pkg::SC_COIN2,
			key_map_pkg::SC_START1, key_map_pkg::SC_START2, key_map_pkg::SC_SERVICE};
		for (int i = 0; i < 6; i++) begin
			exp = ~(6'b100000 >> i); // Same order as the board vector
			press_key(codes[i], 1'b1);
			wait_two_edges();
			check_buttons($sformatf("key %h press", codes[i]), exp);
			press_key(codes[i], 1'b0);
			wait_two_edges();
			check_buttons($sformatf("key %h release", codes[i]), '1);
		end
		press_key(8'h1C, 1'b1); // Unmapped letter key
		wait_two_edges();
		check_buttons("unmapped key", '1);
		press_key(8'h1C, 1'b0);
		@(posedge CLK_12M);
		fire_in_n <= 1'b0;
		wait_two_edges();
		check_buttons("cabinet fire", 6'b011111);
		@(posedge CLK_12M);
		fire_in_n <= 1'b1;
		send_mouse(8'sd0, 2'b10);
		wait_two_edges();
		check_buttons("mouse button", 6'b011111);
		send_mouse(8'sd0, 2'b00);
		wait_two_edges();
		check_buttons("mouse release", '1);
		finish_test("buttons");
	endtask

	task automatic test_mouse_paddle();
		int deltas[5];
		deltas = '{5, -7, 0, 0, 0};
		for (int i = 2; i < 5; i++) deltas[i] = $random(seed) % 41; // -40 to 40
		for (int i = 0; i < 5; i++) begin
			clear_steps();
			send_mouse(paddle_pkg::mouse_delta_t'(deltas[i]), 2'b00);
			drain_steps($sformatf("mouse %0d", deltas[i]),
				deltas[i] < 0 ? -deltas[i] : deltas[i], deltas[i] < 0);
		end
		finish_test("mouse_paddle");
	endtask

	// Hold a direction key a little over one poll period
	task automatic hold_pad(input string name, input key_map_pkg::scan_code_t code,
			input logic fast, input int n, input logic neg);
		clear_steps();
		if (fast) press_key(key_map_pkg::SC_FAST, 1'b1);
		press_key(code, 1'b1);
		repeat (2 * POLL_DIV + 8) @(posedge CLK_12M);
		press_key(code, 1'b0);
		if (fast) press_key(key_map_pkg::SC_FAST, 1'b0);
		drain_steps(name, n, neg);
	endtask

	task automatic test_digital_paddle();
		hold_pad("right slow", key_map_pkg::SC_RIGHT, 1'b0, int'(paddle_pkg::DPAD_SLOW), 1'b0);
		hold_pad("right fast", key_map_pkg::SC_RIGHT, 1'b1, int'(paddle_pkg::DPAD_FAST), 1'b0);
		hold_pad("left slow", key_map_pkg::SC_LEFT, 1'b0, int'(paddle_pkg::DPAD_SLOW), 1'b1);
		finish_test("digital_paddle");
	endtask

	task automatic test_encoder_handover();
		int d;
		count_en = 1'b0; // Source switch is no step
		for (int i = 0; i < 8; i++) begin
			turn_encoder(i >= 4);
			wait_two_edges();
			check_quad($sformatf("encoder turn %0d", i), raw_expected);
		end
		// Real phase moved off the emulated one so the switch back shows
		if (raw_expected == emu_expected) begin
			turn_encoder(1'b1);
			wait_two_edges();
			check_quad("encoder extra turn", raw_expected);
		end
		d = $random(seed) % 41;
		send_mouse(paddle_pkg::mouse_delta_t'(d), 2'b00);
		repeat (3) @(posedge CLK_12M);
		@(negedge CLK_12M);
		check_quad("back to emulated", emu_expected);
		clear_steps();
		count_en = 1'b1;
		drain_steps($sformatf("handover mouse %0d", d), d < 0 ? -d : d, d < 0);
		finish_test("encoder_handover");
	endtask

	initial begin
		rst_n = 1'b0;
		ps2_key = '0;
		ps2_mouse = '0;
		enc_a = 1'b0;
		enc_b = 1'b0;
		fire_in_n = 1'b1;
		{errors, tests_run, tests_failed, test_start_errors} = '0;
		{pos_steps, neg_steps, bad_steps} = '0;
		count_en = 1'b1;
		emu_expected = paddle_pkg::QUAD_IDLE;
		raw_expected = paddle_pkg::QUAD_IDLE;
		repeat (2) @(posedge CLK_12M);
		rst_n <= 1'b1;
		test_reset_values();
		test_buttons();
		test_mouse_paddle();
		test_digital_paddle();
		test_encoder_handover();
		errors += i_arkanoid_controls.i_paddle_position.i_paddle_props.fail_count;
		errors += i_arkanoid_controls.i_cabinet_outputs.i_cabinet_props.fail_count;
		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// Watchdog, sized from the longest possible step drain
	initial begin
		#(WATCHDOG_CLKS * CLK_PERIOD);
		$display("watchdog expired before the tests finished");
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- sim/arkanoid_controls_props.sv
`timescale 1ns/100ps

// ======================================================================
// Bound checks for the paddle and board side
// ======================================================================
module arkanoid_controls_props (
	input logic                    CLK_12M,
	input logic                    rst_n,
	input logic                    tick,
	input logic                    move_add,
	input logic                    move_load,
	input paddle_pkg::quad_t       quad,    // Encoder phase under test
	input key_map_pkg::board_btn_t board_n
);

	int fail_count = 0; // Failed assertions so far

	// Motion pulses only on tick cycles
	pulse_on_tick: assert property (@(posedge CLK_12M) disable iff (!rst_n)
		(move_add || move_load) |-> tick)
	else begin
		$error("move pulse outside a tick cycle");
		fail_count++;
	end

	// One Gray step per change, never two bits
	quad_gray: assert property (@(posedge CLK_12M) disable iff (!rst_n)
		(quad != $past(quad)) |-> ($countones(quad ^ $past(quad)) == 1))
	else begin
		$error("encoder phase jumped by more than one step");
		fail_count++;
	end

	// Values set by the previous reset edge
	reset_values: assert property (@(posedge CLK_12M)
		!rst_n |=> (quad == paddle_pkg::QUAD_IDLE) && (board_n == '1))
	else begin
		$error("output left its reset value during reset");
		fail_count++;
	end

endmodule

bind paddle_position arkanoid_controls_props i_paddle_props (
	.CLK_12M(CLK_12M), .rst_n(rst_n), .tick(tick),
	.move_add(move_add), .move_load(move_load),
	.quad(emu_quad), .board_n('1) // No board outputs in this block
);

bind cabinet_outputs arkanoid_controls_props i_cabinet_props (
	.CLK_12M(CLK_12M), .rst_n(rst_n), .tick(1'b1), // Tick rule covered in paddle_position
	.move_add(move_add), .move_load(move_load),
	.quad(raw_quad), .board_n(board_n)
);

//--- logic/arkanoid_controls.sv
`timescale 1ns/100ps

// ======================================================================
// Player controls front end
// ======================================================================
module arkanoid_controls #(
	parameter int step_div = paddle_pkg::STEP_DIV_DEFAULT,
	parameter int poll_div = paddle_pkg::POLL_DIV_DEFAULT
) (
	input  logic              CLK_12M,
	input  logic              rst_n,
	input  logic [10:0]       ps2_key,   // toggle, pressed, -, code
	input  logic [24:0]       ps2_mouse, // toggle, ..., X delta, ..., buttons
	input  logic              enc_a,
	input  logic              enc_b,
	input  logic              fire_in_n,
	output paddle_pkg::quad_t spinner,
	output logic              shot_n,
	output logic              coin1_n,
	output logic              coin2_n,
	output logic              start1_n,
	output logic              start2_n,
	output logic              service_n
);

	logic                  btn_fire, btn_fast, btn_left, btn_right;
	logic                  btn_coin1, btn_coin2, btn_service, btn_start1, btn_start2;
	logic                  tick;
	logic                  move_add;
	logic                  move_load;
	paddle_pkg::position_t move_value;
	paddle_pkg::quad_t     emu_quad;

	// ==================================================================
	// Decode
	// ==================================================================
	key_decoder i_key_decoder (
		.CLK_12M(CLK_12M), .rst_n(rst_n),
		.key_toggle(ps2_key[10]), .key_pressed(ps2_key[9]), .key_code(ps2_key[7:0]),
		.btn_fire(btn_fire), .btn_fast(btn_fast), .btn_left(btn_left),
		.btn_right(btn_right), .btn_coin1(btn_coin1), .btn_coin2(btn_coin2),
		.btn_service(btn_service), .btn_start1(btn_start1), .btn_start2(btn_start2)
	);

	motion_decoder #(.poll_div(poll_div)) i_motion_decoder (
		.CLK_12M(CLK_12M), .rst_n(rst_n),
		.mouse_toggle(ps2_mouse[24]), .mouse_dx(ps2_mouse[15:8]),
		.dpad_left(btn_left), .dpad_right(btn_right), .dpad_fast(btn_fast),
		.tick(tick), .move_add(move_add), .move_load(move_load), .move_value(move_value)
	);

	// Emulated encoder
	paddle_position #(.step_div(step_div)) i_paddle_position (
		.CLK_12M(CLK_12M), .rst_n(rst_n), .tick(tick),
		.move_add(move_add), .move_load(move_load), .move_value(move_value),
		.emu_quad(emu_quad)
	);

	// Board side
	cabinet_outputs i_cabinet_outputs (
		.CLK_12M(CLK_12M), .rst_n(rst_n),
		.enc_a(enc_a), .enc_b(enc_b), .fire_in_n(fire_in_n),
		.mouse_buttons(ps2_mouse[1:0]),
		.move_add(move_add), .move_load(move_load), .emu_quad(emu_quad),
		.btn_fire(btn_fire), .btn_coin1(btn_coin1), .btn_coin2(btn_coin2),
		.btn_service(btn_service), .btn_start1(btn_start1), .btn_start2(btn_start2),
		.spinner(spinner), .shot_n(shot_n), .coin1_n(coin1_n), .coin2_n(coin2_n),
		.start1_n(start1_n), .start2_n(start2_n), .service_n(service_n)
	);

endmodule

//--- logic/cabinet_outputs.sv
`timescale 1ns/100ps

// ======================================================================
// Real encoder follower, source select and board inputs
// ======================================================================
module cabinet_outputs (
	input  logic              CLK_12M,
	input  logic              rst_n,
	input  logic              enc_a,
	input  logic              enc_b,
	input  logic              fire_in_n,     // Cabinet button, active low
	input  logic [1:0]        mouse_buttons,
	input  logic              move_add,
	input  logic              move_load,
	input  paddle_pkg::quad_t emu_quad,
	input  logic              btn_fire,
	input  logic              btn_coin1,
	input  logic              btn_coin2,
	input  logic              btn_service,
	input  logic              btn_start1,
	input  logic              btn_start2,
	output paddle_pkg::quad_t spinner,
	output logic              shot_n,
	output logic              coin1_n,
	output logic              coin2_n,
	output logic              start1_n,
	output logic              start2_n,
	output logic              service_n
);

	logic [1:0]              old_pins; // {b, a} last cycle
	logic                    pins_moved;
	logic                    use_io;   // 1 real encoder, 0 emulated
	logic                    fire_any;
	paddle_pkg::quad_t       raw_quad;
	key_map_pkg::board_btn_t board_n;

	assign pins_moved = ({enc_b, enc_a} != old_pins);
	assign fire_any   = btn_fire | (|mouse_buttons) | ~fire_in_n;
	assign spinner    = use_io ? raw_quad : emu_quad;

	assign {shot_n, coin1_n, coin2_n, start1_n, start2_n, service_n} = board_n;

	// ==================================================================
	// Encoder follower and source flag
	// ==================================================================
	always_ff @(posedge CLK_12M) begin
		if (!rst_n) begin
			old_pins <= {enc_b, enc_a};
			raw_quad <= paddle_pkg::QUAD_IDLE;
			use_io   <= 1'b0;
		end else begin
			old_pins <= {enc_b, enc_a};
			// One phase per A edge, direction from A vs B
			if (enc_a != old_pins[0]) begin
				raw_quad <= paddle_pkg::quad_step(raw_quad, enc_a ^ enc_b);
			end
			if (pins_moved) begin
				use_io <= 1'b1; // Pin activity wins
			end else if (move_add || move_load) begin
				use_io <= 1'b0;
			end
		end
	end

	// Board inputs, registered and inverted
	always_ff @(posedge CLK_12M) begin
		if (!rst_n) begin
			board_n <= '1; // Nothing pressed
		end else begin
			board_n <= ~{fire_any, btn_coin1, btn_coin2, btn_start1, btn_start2, btn_service};
		end
	end

endmodule

//--- logic/paddle_position.sv
`timescale 1ns/100ps

// ======================================================================
// Owed-step accumulator and emulated AB encoder
// ======================================================================
module paddle_position #(
	parameter int step_div = paddle_pkg::STEP_DIV_DEFAULT
) (
	input  logic                  CLK_12M,
	input  logic                  rst_n,
	input  logic                  tick,
	input  logic                  move_add,
	input  logic                  move_load,
	input  paddle_pkg::position_t move_value,
	output paddle_pkg::quad_t     emu_quad
);

	localparam paddle_pkg::div_count_t STEP_LAST = paddle_pkg::div_count_t'(step_div - 1);
	localparam int                     SIGN_BIT  = paddle_pkg::POSITION_W - 1;

	paddle_pkg::position_t  position;      // Steps still owed
	paddle_pkg::position_t  position_base; // After this cycle's step
	paddle_pkg::div_count_t step_cnt;
	logic                   step_due;
	logic                   pos_neg;
	logic                   add_ok;

	assign pos_neg  = position[SIGN_BIT];
	assign step_due = tick && (step_cnt == '0) && (position != '0);
	// Room left only while the top two bits agree
	assign add_ok   = (position[SIGN_BIT] == position[SIGN_BIT-1]);

	// One step toward zero
	always_comb begin
		if (!step_due) begin
			position_base = position;
		end else if (pos_neg) begin
			position_base = position + 12'sd1;
		end else begin
			position_base = position - 12'sd1;
		end
	end

	// ==================================================================
	// Step rate divider, free running on ticks
	// ==================================================================
	always_ff @(posedge CLK_12M) begin
		if (!rst_n) begin
			step_cnt <= '0;
		end else if (tick) begin
			if (step_cnt == STEP_LAST) begin
				step_cnt <= '0;
			end else begin
				step_cnt <= step_cnt + 1'b1;
			end
		end
	end

	// ==================================================================
	// Position and phase
	// ==================================================================
	always_ff @(posedge CLK_12M) begin
		if (!rst_n) begin
			position <= '0;
			emu_quad <= paddle_pkg::QUAD_IDLE;
		end else begin
			if (step_due) begin
				emu_quad <= paddle_pkg::quad_step(emu_quad, pos_neg); // Direction from sign
			end
			if (move_load) begin
				position <= move_value; // Digital paddle overwrites
			end else if (move_add && add_ok) begin
				position <= position_base + move_value;
			end else begin
				position <= position_base; // Guarded add is dropped
			end
		end
	end

endmodule

//--- logic/motion_decoder.sv
`timescale 1ns/100ps

// ======================================================================
// 6 MHz tick, mouse X reports and digital paddle reloads
// ======================================================================
module motion_decoder #(
	parameter int poll_div = paddle_pkg::POLL_DIV_DEFAULT
) (
	input  logic                     CLK_12M,
	input  logic                     rst_n,
	input  logic                     mouse_toggle, // Flips once per report
	input  paddle_pkg::mouse_delta_t mouse_dx,
	input  logic                     dpad_left,
	input  logic                     dpad_right,
	input  logic                     dpad_fast,
	output logic                     tick,       // High every second clock
	output logic                     move_add,   // Add move_value to position
	output logic                     move_load,  // Replace position by move_value
	output paddle_pkg::position_t    move_value
);

	localparam int PAD_W = paddle_pkg::POSITION_W - paddle_pkg::MOUSE_DX_W;

	logic                   old_toggle;
	logic                   mouse_evt;
	logic                   dpad_held;
	logic                   poll_hit;
	paddle_pkg::div_count_t poll_cnt;
	paddle_pkg::position_t  mouse_value;
	paddle_pkg::position_t  dpad_value;

	assign mouse_evt   = (mouse_toggle != old_toggle);
	assign dpad_held   = dpad_left | dpad_right;
	assign poll_hit    = dpad_held && (poll_cnt == paddle_pkg::div_count_t'(poll_div - 1));
	assign mouse_value = {{PAD_W{mouse_dx[paddle_pkg::MOUSE_DX_W-1]}}, mouse_dx}; // Sign extend

	// Right wins when both are held
	always_comb begin
		if (dpad_right) begin
			dpad_value = dpad_fast ? paddle_pkg::DPAD_FAST : paddle_pkg::DPAD_SLOW;
		end else begin
			dpad_value = dpad_fast ? -paddle_pkg::DPAD_FAST : -paddle_pkg::DPAD_SLOW;
		end
	end

	// Halve the 12 MHz clock
	always_ff @(posedge CLK_12M) begin
		if (!rst_n) begin
			tick <= 1'b0;
		end else begin
			tick <= ~tick;
		end
	end

	// ==================================================================
	// Decisions are taken on the cycle before a tick,
	// so every pulse lands on a tick cycle
	// ==================================================================
	always_ff @(posedge CLK_12M) begin
		if (!rst_n) begin
			old_toggle <= mouse_toggle;
			poll_cnt   <= '0;
			move_add   <= 1'b0;
			move_load  <= 1'b0;
		end else begin
			move_add  <= 1'b0; // Pulses last one cycle
			move_load <= 1'b0;
			if (!tick) begin
				if (!dpad_held || poll_hit) begin
					poll_cnt <= '0; // Release clears, hit restarts
				end else begin
					poll_cnt <= poll_cnt + 1'b1;
				end
				if (poll_hit) begin
					move_load <= 1'b1; // Mouse report waits one tick
				end else begin
					old_toggle <= mouse_toggle;
					move_add   <= mouse_evt;
				end
			end
		end
	end

	// Value goes with whichever pulse fires
	always_ff @(posedge CLK_12M) begin
		if (!tick) begin
			move_value <= poll_hit ? dpad_value : mouse_value;
		end
	end

endmodule

//--- logic/key_decoder.sv
`timescale 1ns/100ps

// ======================================================================
// PS/2 key reports to held button levels
// ======================================================================
module key_decoder (
	input  logic                    CLK_12M,
	input  logic                    rst_n,
	input  logic                    key_toggle,  // Flips once per report
	input  logic                    key_pressed, // 1 make, 0 break
	input  key_map_pkg::scan_code_t key_code,
	output logic                    btn_fire,
	output logic                    btn_fast,
	output logic                    btn_left,
	output logic                    btn_right,
	output logic                    btn_coin1,
	output logic                    btn_coin2,
	output logic                    btn_service,
	output logic                    btn_start1,
	output logic                    btn_start2
);

	logic old_toggle;
	logic new_report;

	assign new_report = (key_toggle != old_toggle);

	always_ff @(posedge CLK_12M) begin
		if (!rst_n) begin
			old_toggle  <= key_toggle; // Track, so leaving reset is no report
			btn_fire    <= 1'b0;
			btn_fast    <= 1'b0;
			btn_left    <= 1'b0;
			btn_right   <= 1'b0;
			btn_coin1   <= 1'b0;
			btn_coin2   <= 1'b0;
			btn_service <= 1'b0;
			btn_start1  <= 1'b0;
			btn_start2  <= 1'b0;
		end else begin
			old_toggle <= key_toggle;
			if (new_report) begin
				// Level follows make/break of the matching key
				case (key_code)
					key_map_pkg::SC_FIRE:    btn_fire    <= key_pressed;
					key_map_pkg::SC_FAST:    btn_fast    <= key_pressed;
					key_map_pkg::SC_LEFT:    btn_left    <= key_pressed;
					key_map_pkg::SC_RIGHT:   btn_right   <= key_pressed;
					key_map_pkg::SC_COIN1:   btn_coin1   <= key_pressed;
					key_map_pkg::SC_COIN2:   btn_coin2   <= key_pressed;
					key_map_pkg::SC_SERVICE: btn_service <= key_pressed;
					key_map_pkg::SC_START1:  btn_start1  <= key_pressed;
					key_map_pkg::SC_START2:  btn_start2  <= key_pressed;
					default: ; // Other keys, nothing to hold
				endcase
			end
		end
	end

endmodule

//--- logic/paddle_pkg.sv
// ======================================================================
// Paddle side: position, encoder phase and divider definitions
// ======================================================================
package paddle_pkg;

	localparam int POSITION_W = 12;
	localparam int MOUSE_DX_W = 8;

	// Steps still owed to the board, sign gives direction
	typedef logic signed [POSITION_W-1:0] position_t;
	// X field of a mouse report
	typedef logic signed [MOUSE_DX_W-1:0] mouse_delta_t;
	// AB encoder phase, bit 1 is A
	typedef logic [1:0] quad_t;
	// Shared by step and poll dividers
	typedef logic [15:0] div_count_t;

	localparam quad_t QUAD_IDLE = 2'b11; // Both lines released

	// Divider lengths, counted in 6 MHz ticks
	localparam int STEP_DIV_DEFAULT = 1500;  // ~4 kHz step rate
	localparam int POLL_DIV_DEFAULT = 48000; // ~8 ms, like a 125 Hz mouse poll

	// Digital paddle reload sizes
	localparam position_t DPAD_SLOW = 12'sd4;
	localparam position_t DPAD_FAST = 12'sd9;

	// One Gray step of the encoder
	// Negative: 00 -> 01 -> 11 -> 10 -> 00
	// Positive: 00 -> 10 -> 11 -> 01 -> 00
	function automatic quad_t quad_step(input quad_t q, input logic neg);
		quad_t nxt;
		if (neg) begin
			nxt = {q[0], ~q[1]};
		end else begin
			nxt = {~q[0], q[1]};
		end
		return nxt;
	endfunction

endpackage

//--- logic/key_map_pkg.sv
// ======================================================================
// Keyboard side: PS/2 set-2 codes and board button set
// ======================================================================
package key_map_pkg;

	// Raw make/break code, no E0 prefix
	typedef logic [7:0] scan_code_t;

	// Cabinet keys
	localparam scan_code_t SC_START1  = 8'h16; // 1
	localparam scan_code_t SC_START2  = 8'h1E; // 2
	localparam scan_code_t SC_COIN1   = 8'h2E; // 5
	localparam scan_code_t SC_COIN2   = 8'h36; // 6
	localparam scan_code_t SC_SERVICE = 8'h46; // 9

	// Play keys
	localparam scan_code_t SC_FAST    = 8'h11; // Alt, speeds up the digital paddle
	localparam scan_code_t SC_LEFT    = 8'h6B; // Cursor left
	localparam scan_code_t SC_RIGHT   = 8'h74; // Cursor right
	localparam scan_code_t SC_FIRE    = 8'h29; // Space

	// Active-low inputs of the game board
	// Order: shot, coin1, coin2, start1, start2, service
	localparam int BOARD_BTN_W = 6;

	typedef logic [BOARD_BTN_W-1:0] board_btn_t;

endpackage
